// File: include/dbg_regs.svh
`ifndef DBG_REGS_SVH
`define DBG_REGS_SVH

// Host bridge register map
`define DBG_REG_TX      4'h0
`define DBG_REG_RX      4'h4
`define DBG_REG_STATUS  4'h8

`define LAST_BIT        16   // Flit last flag in TX and RX words
`define RX_VALID_BIT    31   // RX word holds a flit

`endif

// File: rtl/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

   // One link word between debug modules
   typedef struct packed {
      logic        valid;
      logic        last;
      logic [15:0] data;
   } dii_flit;

   typedef enum logic [1:0] {
      CMD_READ  = 2'd0,
      CMD_WRITE = 2'd1,
      CMD_RESP  = 2'd2
   } dbg_cmd_e;

   // First flit of every packet
   typedef struct packed {
      logic [9:0] dest;
      dbg_cmd_e   cmd;
      logic [3:0] reg_addr;
   } dii_hdr_t;

   typedef union packed {
      logic [15:0] raw;
      dii_hdr_t    hdr;
   } dii_word_u;

   localparam logic [9:0] HOST_ID = 10'd0;   // Destination of responses

endpackage

`default_nettype wire

// File: rtl/dbg_flit_fifo.sv
`default_nettype none

module dbg_flit_fifo #(
   parameter int DEPTH = 4
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  dbg_pkg::dii_flit       in_flit,
   output logic                   in_ready,
   output dbg_pkg::dii_flit       out_flit,
   input  logic                   out_ready,
   output logic [$clog2(DEPTH):0] count
);

   localparam int AW = $clog2(DEPTH);

   logic [16:0]   mem [DEPTH];   // {last, data}
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic          push;
   logic          pop;
   logic          full;
   logic          empty;

   assign full     = (count == (AW + 1)'(DEPTH));
   assign empty    = (count == '0);
   assign in_ready = ~full;
   assign push     = in_flit.valid & in_ready;
   assign pop      = out_ready & ~empty;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= {in_flit.last, in_flit.data};
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

   // Head flit shown ahead of the pop
   assign out_flit = '{valid: ~empty, last: mem[rd_ptr][16], data: mem[rd_ptr][15:0]};

endmodule

`default_nettype wire

// File: rtl/dbg_host_apb.sv
`default_nettype none

`include "dbg_regs.svh"

module dbg_host_apb #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [3:0]                  paddr,
   input  logic                        psel,
   input  logic                        penable,
   input  logic                        pwrite,
   input  logic [31:0]                 pwdata,
   output logic [31:0]                 prdata,
   output logic                        pready,
   output logic                        pslverr,
   output dbg_pkg::dii_flit            req_in,
   input  logic                        req_in_ready,
   input  dbg_pkg::dii_flit            rsp_out,
   output logic                        rsp_out_ready,
   input  logic [$clog2(FIFO_DEPTH):0] rsp_count
);

   logic        setup;
   logic        access;
   logic        tx_write;
   logic        rx_read;
   logic        rx_avail_q;
   logic [31:0] rdata_mux;
   logic [31:0] rdata_q;

   assign setup    = psel & ~penable;
   assign access   = psel & penable;
   assign tx_write = access & pwrite & (paddr == `DBG_REG_TX);
   assign rx_read  = access & ~pwrite & (paddr == `DBG_REG_RX);

   assign pready  = 1'b1;
   assign pslverr = tx_write & ~req_in_ready;   // Request FIFO full, flit lost

   // Push only when it is sure to be taken
   assign req_in = '{valid: tx_write & req_in_ready,
                     last:  pwdata[`LAST_BIT],
                     data:  pwdata[15:0]};

   always_comb begin
      rdata_mux = '0;
      case (paddr)
         `DBG_REG_RX: begin
            if (rsp_out.valid) begin
               rdata_mux[`RX_VALID_BIT] = 1'b1;
               rdata_mux[`LAST_BIT]     = rsp_out.last;
               rdata_mux[15:0]          = rsp_out.data;
            end
         end
         `DBG_REG_STATUS: begin
            rdata_mux[0]   = ~req_in_ready;
            rdata_mux[7:4] = 4'(rsp_count);
         end
         default: ;
      endcase
   end

   // Read data captured in the setup phase
   always_ff @(posedge clk) begin
      if (setup && !pwrite) begin
         rdata_q <= rdata_mux;
      end
   end

   // Head only changes by our own pop, so the sampled flit is still there
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rx_avail_q <= 1'b0;
      end else if (setup) begin
         rx_avail_q <= ~pwrite & (paddr == `DBG_REG_RX) & rsp_out.valid;
      end
   end

   assign prdata        = rdata_q;
   assign rsp_out_ready = rx_read & rx_avail_q;

endmodule

`default_nettype wire

// File: rtl/dbg_scm.sv
`default_nettype none

module dbg_scm #(
   parameter logic [9:0]  SCM_ID    = 10'd1,
   parameter logic [15:0] SYSTEM_ID = 16'h5a17
) (
   input  logic             clk,
   input  logic             rst_n,
   input  dbg_pkg::dii_flit req_out,
   output logic             req_out_ready,
   output dbg_pkg::dii_flit rsp_in,
   input  logic             rsp_in_ready,
   output logic             sys_rst,
   output logic             cpu_rst
);

   typedef enum logic [2:0] {
      HEADER,
      WDATA,
      DRAIN,
      RSP_HDR,
      RSP_DATA
   } state_e;

   state_e             state;
   dbg_pkg::dii_word_u in_word;
   dbg_pkg::dii_word_u rsp_word;
   logic               req_take;
   logic               for_me;
   logic               is_write;
   logic               is_read;
   logic [3:0]         addr_q;
   logic [1:0]         ctrl;
   logic [15:0]        scratch;
   logic [15:0]        rd_data;

   assign req_out_ready = (state == HEADER) || (state == WDATA) || (state == DRAIN);
   assign req_take      = req_out.valid & req_out_ready;

   always_comb begin
      in_word.raw = req_out.data;
   end

   assign for_me   = (in_word.hdr.dest == SCM_ID);
   assign is_write = for_me & (in_word.hdr.cmd == dbg_pkg::CMD_WRITE);
   assign is_read  = for_me & (in_word.hdr.cmd == dbg_pkg::CMD_READ);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= HEADER;
      end else begin
         case (state)
            HEADER: begin
               if (req_take) begin
                  if (is_write && !req_out.last) state <= WDATA;
                  else if (is_read && req_out.last) state <= RSP_HDR;
                  else if (!req_out.last) state <= DRAIN;   // Foreign or unknown
               end
            end
            WDATA: begin
               if (req_take) state <= req_out.last ? HEADER : DRAIN;
            end
            DRAIN: begin
               if (req_take && req_out.last) state <= HEADER;
            end
            RSP_HDR: begin
               if (rsp_in_ready) state <= RSP_DATA;
            end
            RSP_DATA: begin
               if (rsp_in_ready) state <= HEADER;
            end
            default: state <= HEADER;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == HEADER && req_take) begin
         addr_q <= in_word.hdr.reg_addr;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ctrl    <= '0;
         scratch <= '0;
      end else if (state == WDATA && req_take) begin
         case (addr_q)
            4'd0:    ctrl    <= req_out.data[1:0];
            4'd1:    scratch <= req_out.data;
            default: ;   // SYSID and holes are read only
         endcase
      end
   end

   always_comb begin
      case (addr_q)
         4'd0:    rd_data = {14'd0, ctrl};
         4'd1:    rd_data = scratch;
         4'd2:    rd_data = SYSTEM_ID;
         default: rd_data = '0;
      endcase
   end

   always_comb begin
      rsp_word.hdr.dest     = dbg_pkg::HOST_ID;
      rsp_word.hdr.cmd      = dbg_pkg::CMD_RESP;
      rsp_word.hdr.reg_addr = addr_q;
   end

   assign rsp_in = '{valid: (state == RSP_HDR) || (state == RSP_DATA),
                     last:  (state == RSP_DATA),
                     data:  (state == RSP_HDR) ? rsp_word.raw : rd_data};

   assign sys_rst = ctrl[0];
   assign cpu_rst = ctrl[1];

endmodule

`default_nettype wire

// File: rtl/debug_system.sv
`default_nettype none

module debug_system #(
   parameter int          FIFO_DEPTH = 4,
   parameter logic [9:0]  SCM_ID     = 10'd1,
   parameter logic [15:0] SYSTEM_ID  = 16'h5a17
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [3:0]  paddr,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   output logic        sys_rst,
   output logic        cpu_rst
);

   dbg_pkg::dii_flit                req_in;
   logic                            req_in_ready;
   dbg_pkg::dii_flit                req_out;
   logic                            req_out_ready;
   logic [$clog2(FIFO_DEPTH):0]     req_count;
   dbg_pkg::dii_flit                rsp_in;
   logic                            rsp_in_ready;
   dbg_pkg::dii_flit                rsp_out;
   logic                            rsp_out_ready;
   logic [$clog2(FIFO_DEPTH):0]     rsp_count;

   dbg_host_apb #(.FIFO_DEPTH(FIFO_DEPTH)) u_host (
      .clk(clk), .rst_n(rst_n),
      .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
      .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .req_in(req_in), .req_in_ready(req_in_ready),
      .rsp_out(rsp_out), .rsp_out_ready(rsp_out_ready), .rsp_count(rsp_count)
   );

   dbg_flit_fifo #(.DEPTH(FIFO_DEPTH)) u_req_fifo (
      .clk(clk), .rst_n(rst_n),
      .in_flit(req_in), .in_ready(req_in_ready),
      .out_flit(req_out), .out_ready(req_out_ready), .count(req_count)
   );

   dbg_scm #(.SCM_ID(SCM_ID), .SYSTEM_ID(SYSTEM_ID)) u_scm (
      .clk(clk), .rst_n(rst_n),
      .req_out(req_out), .req_out_ready(req_out_ready),
      .rsp_in(rsp_in), .rsp_in_ready(rsp_in_ready),
      .sys_rst(sys_rst), .cpu_rst(cpu_rst)
   );

   dbg_flit_fifo #(.DEPTH(FIFO_DEPTH)) u_rsp_fifo (
      .clk(clk), .rst_n(rst_n),
      .in_flit(rsp_in), .in_ready(rsp_in_ready),
      .out_flit(rsp_out), .out_ready(rsp_out_ready), .count(rsp_count)
   );

endmodule

`default_nettype wire

// File: verification/debug_system_properties.sv
`default_nettype none

module debug_system_properties #(
   parameter int FIFO_DEPTH = 4
) (
   input logic                        clk,
   input logic                        rst_n,
   input logic                        psel,
   input logic                        penable,
   input logic                        pslverr,
   input dbg_pkg::dii_flit            req_out,
   input logic                        req_out_ready,
   input dbg_pkg::dii_flit            rsp_in,
   input logic                        rsp_in_ready,
   input dbg_pkg::dii_flit            rsp_out,
   input logic                        rsp_out_ready,
   input logic [$clog2(FIFO_DEPTH):0] req_count,
   input logic [$clog2(FIFO_DEPTH):0] rsp_count
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0;   // Read by the testbench top

   task automatic flag_violation(input string what);
      fail_count++;
      $error("%s", what);
   endtask

   a_pslverr_access: assert property (@(posedge clk) disable iff (!rst_n)
      pslverr |-> (psel && penable))
      else flag_violation("pslverr high outside an APB access cycle");

   a_req_out_held: assert property (@(posedge clk) disable iff (!rst_n)
      (req_out.valid && !req_out_ready) |=> $stable(req_out))
      else flag_violation("req_out flit changed while stalled");

   a_rsp_in_held: assert property (@(posedge clk) disable iff (!rst_n)
      (rsp_in.valid && !rsp_in_ready) |=> $stable(rsp_in))
      else flag_violation("rsp_in flit changed while stalled");

   a_rsp_out_held: assert property (@(posedge clk) disable iff (!rst_n)
      (rsp_out.valid && !rsp_out_ready) |=> $stable(rsp_out))
      else flag_violation("rsp_out flit changed while stalled");

   // Both FIFOs share one depth
   a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
      (req_count <= FIFO_DEPTH) && (rsp_count <= FIFO_DEPTH))
      else flag_violation("FIFO count above FIFO_DEPTH");

endmodule

`default_nettype wire

// File: verification/tb_debug_system.sv
`default_nettype none

`include "dbg_regs.svh"

module tb_debug_system;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          FIFO_DEPTH = 4;
   localparam logic [9:0]  SCM_ID     = 10'd1;
   localparam logic [15:0] SYSTEM_ID  = 16'h5a17;
   localparam int          MAX_POLLS  = 30;

   logic        clk = 1'b0;
   logic        rst_n;
   logic [3:0]  paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        sys_rst;
   logic        cpu_rst;

   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   int          cycle_limit = 500;   // Grows by 200 per case line
   logic [31:0] lcg_state = 32'd91726;
   logic [15:0] last_rnd = '0;

   debug_system #(.FIFO_DEPTH(FIFO_DEPTH), .SCM_ID(SCM_ID), .SYSTEM_ID(SYSTEM_ID)) u_dut (
      .clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
      .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr), .sys_rst(sys_rst), .cpu_rst(cpu_rst)
   );

   bind debug_system debug_system_properties #(.FIFO_DEPTH(FIFO_DEPTH)) u_props (
      .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pslverr(pslverr),
      .req_out(req_out), .req_out_ready(req_out_ready),
      .rsp_in(rsp_in), .rsp_in_ready(rsp_in_ready),
      .rsp_out(rsp_out), .rsp_out_ready(rsp_out_ready),
      .req_count(req_count), .rsp_count(rsp_count)
   );

   always begin
      #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Some tests failed");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [15:0] make_header(input logic [9:0] dest,
                                               input dbg_pkg::dbg_cmd_e cmd,
                                               input logic [3:0] reg_addr);
      dbg_pkg::dii_word_u w;
      w.hdr.dest     = dest;
      w.hdr.cmd      = cmd;
      w.hdr.reg_addr = reg_addr;
      return w.raw;
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED at %0d ns: %s, got %h, expected %h",
                  $time, what, actual, expected);
      end
   endtask

   task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      #1;
      err = pslverr;   // Settled inside the access cycle
      check_value(32'(pready), 32'd1, "pready in write access cycle");
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      #1;
      data = prdata;
      check_value(32'(pready), 32'd1, "pready in read access cycle");
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic send_flit(input logic [15:0] data, input logic last);
      logic err;
      apb_write(`DBG_REG_TX, {15'd0, last, data}, err);
      check_value(32'(err), 32'd0, "pslverr on TX write");
   endtask

   task automatic pop_flit(output logic got, output logic [31:0] word);
      got = 1'b0;
      for (int i = 0; i < MAX_POLLS && !got; i++) begin
         apb_read(`DBG_REG_RX, word);
         got = word[`RX_VALID_BIT];
      end
   endtask

   task automatic read_response(input logic [3:0] reg_addr, input logic [15:0] expected);
      logic [31:0]        word;
      logic               got;
      dbg_pkg::dii_word_u w;
      pop_flit(got, word);
      if (got) begin
         w.raw = word[15:0];
         check_value(32'(word[`LAST_BIT]), 32'd0, "last on response header");
         check_value(32'(w.hdr.dest), 32'(dbg_pkg::HOST_ID), "response dest");
         check_value(32'(w.hdr.cmd), 32'(dbg_pkg::CMD_RESP), "response cmd");
         check_value(32'(w.hdr.reg_addr), 32'(reg_addr), "response reg_addr");
         pop_flit(got, word);
      end
      if (!got) begin
         errors++;
         $display("Error at %0d ns: no response arrived for read of register %0d",
                  $time, reg_addr);
      end else begin
         check_value(32'(word[`LAST_BIT]), 32'd1, "last on response data");
         check_value(32'(word[15:0]), 32'(expected),
                     $sformatf("read data of register %0d", reg_addr));
      end
   endtask

   task automatic send_foreign(input logic [9:0] dest);
      logic [31:0] word;
      send_flit(make_header(dest, dbg_pkg::CMD_WRITE, 4'd1), 1'b0);
      send_flit(16'hffff, 1'b1);   // Would clobber SCRATCH if not dropped
      repeat (4) begin
         apb_read(`DBG_REG_RX, word);
         check_value(32'(word[`RX_VALID_BIT]), 32'd0, "RX valid after foreign packet");
      end
   endtask

   task automatic fill_test();
      logic [31:0] word;
      logic        err;
      int          sent;
      sent = 0;
      word = '0;
      while (!word[0] && sent < 4 * FIFO_DEPTH) begin
         send_flit(make_header(SCM_ID, dbg_pkg::CMD_READ, 4'd2), 1'b1);
         sent++;
         apb_read(`DBG_REG_STATUS, word);
      end
      check_value(32'(word[0]), 32'd1, "request FIFO full in STATUS");
      check_value(32'(word[7:4]), 32'(FIFO_DEPTH), "response count in STATUS");
      apb_write(`DBG_REG_TX, {15'd0, 1'b1, make_header(SCM_ID, dbg_pkg::CMD_READ, 4'd2)}, err);
      check_value(32'(err), 32'd1, "pslverr on TX write to full request FIFO");
      repeat (sent) read_response(4'd2, SYSTEM_ID);
      apb_read(`DBG_REG_RX, word);
      check_value(32'(word[`RX_VALID_BIT]), 32'd0, "RX empty after fill test");
   endtask

   initial begin
      int          fd;
      string       op;
      string       f1;
      string       f2;
      logic [15:0] value;
      rst_n   = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      check_value(32'({sys_rst, cpu_rst, pslverr}), 32'd0, "outputs after reset");
      fd = $fopen("verification/debug_cases.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("Error: could not open verification/debug_cases.txt");
      end else begin
         while ($fscanf(fd, "%s", op) == 1) begin
            if (op.substr(0, 0) == "#") begin
               void'($fgets(f1, fd));   // Rest of a comment line
            end else begin
               cycle_limit += 200;
               if (op == "W" || op == "R") begin
                  void'($fscanf(fd, "%s %s", f1, f2));
                  if (op == "W" && f2 == "rnd") begin
                     lcg_state = lcg_next(lcg_state);
                     last_rnd  = lcg_state[31:16];   // Upper bits mix best
                  end
                  value = (f2 == "rnd") ? last_rnd : 16'(f2.atohex());
                  if (op == "W") begin
                     send_flit(make_header(SCM_ID, dbg_pkg::CMD_WRITE, 4'(f1.atoi())), 1'b0);
                     send_flit(value, 1'b1);
                  end else begin
                     send_flit(make_header(SCM_ID, dbg_pkg::CMD_READ, 4'(f1.atoi())), 1'b1);
                     read_response(4'(f1.atoi()), value);
                  end
               end else if (op == "F") begin
                  void'($fscanf(fd, "%s", f1));
                  send_foreign(10'(f1.atoi()));
               end else if (op == "S") begin
                  fill_test();
               end else if (op == "P") begin
                  void'($fscanf(fd, "%s %s", f1, f2));
                  @(negedge clk);
                  check_value(32'(sys_rst), 32'(f1.atoi()), "sys_rst");
                  check_value(32'(cpu_rst), 32'(f2.atoi()), "cpu_rst");
               end else begin
                  errors++;
                  $display("Error: unknown operation %s in case file", op);
               end
            end
         end
         $fclose(fd);
      end
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, u_dut.u_props.fail_count);
      if (errors == 0 && u_dut.u_props.fail_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/debug_cases.txt
# Columns: W reg value | R reg expected | F dest | S | P sys cpu
# reg, dest, sys, cpu in decimal; value and expected in hex, or rnd for the LCG value
R 2 5a17
W 1 rnd
R 1 rnd
R 5 0
W 1 rnd
R 1 rnd
W 0 1
R 0 1
P 1 0
W 0 2
R 0 2
P 0 1
W 0 0
R 0 0
P 0 0
F 3
R 2 5a17
F 0
W 2 1234
R 2 5a17
S
R 1 rnd

// File: compile.f
+incdir+include
rtl/dbg_pkg.sv
rtl/dbg_flit_fifo.sv
rtl/dbg_host_apb.sv
rtl/dbg_scm.sv
rtl/debug_system.sv
verification/debug_system_properties.sv
verification/tb_debug_system.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the debug system testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   -f compile.f --top-module tb_debug_system -o tb_debug_system
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_debug_system +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
   exit 1
fi
exit 0
